/* hdl/crc_defs.svh */
`ifndef CRC_DEFS_SVH
`define CRC_DEFS_SVH

// AHB data bus width
`define CRC_BUS_W 32

// Register word index taken from haddr[4:2]
`define CRC_DR_IDX   3'd0
`define CRC_IDR_IDX  3'd1
`define CRC_CR_IDX   3'd2
`define CRC_INIT_IDX 3'd4
`define CRC_POL_IDX  3'd5

// Reset values of INIT and POL
`define CRC_INIT_RESET 32'hFFFF_FFFF
`define CRC_POL_RESET  32'h04C1_1DB7

// AHB-Lite HTRANS code and the low two bits of HSIZE
`define HTRANS_NONSEQ 2'b10
`define HSIZE_BYTE    2'b00
`define HSIZE_HALF    2'b01
`define HSIZE_WORD    2'b10

`endif

/* hdl/crc_ahb_pkg.sv */
`default_nettype none

// Types seen on the AHB-Lite side of the unit
package crc_ahb_pkg;

	// Word index inside the register window
	typedef logic [2:0] reg_idx_t;

	// Low bits of HSIZE for byte, halfword and word
	typedef logic [1:0] xfer_size_t;

	// IDLE, BUSY, NONSEQ, SEQ
	typedef logic [1:0] htrans_t;

endpackage

`default_nettype wire

/* hdl/crc_core_pkg.sv */
`default_nettype none

`include "crc_defs.svh"

// Types of the CRC datapath
package crc_core_pkg;

	typedef logic [`CRC_BUS_W-1:0] crc_word_t;

	// 00 is 32, 01 is 16, 10 is 8, 11 is 7 bits
	typedef logic [1:0] poly_size_t;

	// 00 none, 01 per byte, 10 per halfword, 11 whole word
	typedef logic [1:0] rev_in_t;

	// Same bit order as CR[7:3]
	typedef struct packed {
		logic       rev_out;
		rev_in_t    rev_in;
		poly_size_t poly_size;
	} crc_cfg_t;

	typedef struct packed {
		crc_word_t               data;
		crc_ahb_pkg::xfer_size_t size;
	} crc_wr_t;

	typedef enum logic {DP_IDLE, DP_SHIFT} dp_state_e;

	// Index of the top CRC bit for a polynomial size
	function automatic logic [4:0] poly_top(input poly_size_t size);
		case (size)
			2'b00: poly_top = 5'd31;
			2'b01: poly_top = 5'd15;
			2'b10: poly_top = 5'd7;
			default: poly_top = 5'd6;
		endcase
	endfunction

	function automatic crc_word_t poly_mask(input poly_size_t size);
		poly_mask = {`CRC_BUS_W{1'b1}} >> (5'd31 - poly_top(size));
	endfunction

endpackage

`default_nettype wire

/* hdl/crc_ahb_regs.sv */
`timescale 1ns/10ps
`default_nettype none

`include "crc_defs.svh"

module crc_ahb_regs
(
	input  wire                          HCLK,
	input  wire                          HRESETn,
	input  wire                          hsel,
	input  wire [`CRC_BUS_W-1:0]         haddr,
	input  wire crc_ahb_pkg::htrans_t    htrans,
	input  wire [2:0]                    hsize,
	input  wire                          hwrite,
	input  wire                          hready,
	input  wire [`CRC_BUS_W-1:0]         hwdata,
	input  wire                          buffer_full,
	input  wire                          chain_busy,
	input  wire crc_core_pkg::crc_word_t crc_view,
	input  wire crc_core_pkg::crc_word_t init_value,
	input  wire crc_core_pkg::crc_word_t pol_value,
	input  wire [7:0]                    idr_value,
	output logic [`CRC_BUS_W-1:0]        hrdata,
	output logic                         hreadyout,
	output logic                         hresp,
	output logic                         buf_wr_en,
	output crc_core_pkg::crc_wr_t        wr_cmd,
	output logic                         init_wr_en,
	output logic                         pol_wr_en,
	output logic                         idr_wr_en,
	output crc_core_pkg::crc_word_t      wr_data,
	output logic                         reset_chain,
	output crc_core_pkg::crc_cfg_t       cfg
);

	import crc_ahb_pkg::*;
	import crc_core_pkg::*;

	// Address phase held for the data phase
	logic       sel_q;
	logic       write_q;
	htrans_t    trans_q;
	reg_idx_t   idx_q;
	xfer_size_t size_q;

	logic      wr_access;
	logic      rd_access;
	logic      dr_wr;
	logic      dr_rd;
	logic      init_wr;
	logic      cr_wr;
	logic      rst_req;
	logic      hold;
	crc_word_t cr_rd;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			sel_q   <= 1'b0;
			write_q <= 1'b0;
			trans_q <= 2'b00;
		end
		else if (hready && hreadyout)
		begin
			sel_q   <= hsel;
			write_q <= hwrite;
			trans_q <= htrans;
			idx_q   <= haddr[4:2];
			size_q  <= hsize[1:0];
		end
	end

	// SEQ beats fall through undecoded
	assign wr_access = sel_q && write_q && (trans_q == `HTRANS_NONSEQ);
	assign rd_access = sel_q && !write_q && (trans_q == `HTRANS_NONSEQ);

	assign dr_wr   = wr_access && (idx_q == `CRC_DR_IDX);
	assign dr_rd   = rd_access && (idx_q == `CRC_DR_IDX);
	assign init_wr = wr_access && (idx_q == `CRC_INIT_IDX);
	assign cr_wr   = wr_access && (idx_q == `CRC_CR_IDX);
	assign rst_req = cr_wr && hwdata[0];

	// Wait states while the execute side cannot accept the access
	assign hold = (dr_wr && buffer_full) ||
		(dr_rd && chain_busy) ||
		((init_wr || rst_req) && chain_busy);

	assign hreadyout = !hold;
	assign hresp     = 1'b0;

	// Strobes fire once, on the last cycle of the data phase
	assign buf_wr_en   = dr_wr && !buffer_full;
	assign init_wr_en  = init_wr && !chain_busy;
	assign reset_chain = rst_req && !chain_busy;
	assign pol_wr_en   = wr_access && (idx_q == `CRC_POL_IDX);
	assign idr_wr_en   = wr_access && (idx_q == `CRC_IDR_IDX);

	// Write data comes straight off the bus
	assign wr_data = hwdata;
	assign wr_cmd  = '{data: hwdata, size: size_q};

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			cfg <= '0;
		else if (cr_wr && !hold)
			cfg <= hwdata[7:3];
	end

	assign cr_rd = {24'h0, cfg, 3'b000};

	always_comb
	begin
		case (idx_q)
			`CRC_DR_IDX: hrdata = crc_view;
			`CRC_IDR_IDX: hrdata = {24'h0, idr_value};
			`CRC_CR_IDX: hrdata = cr_rd;
			`CRC_INIT_IDX: hrdata = init_value;
			`CRC_POL_IDX: hrdata = pol_value;
			default: hrdata = '0;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/crc_data_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "crc_defs.svh"

module crc_data_buffer
(
	input  wire                         HCLK,
	input  wire                         HRESETn,
	input  wire                         buf_wr_en,
	input  wire crc_core_pkg::crc_wr_t  wr_cmd,
	input  wire crc_core_pkg::crc_cfg_t cfg,
	input  wire                         byte_take,
	output logic                        buffer_full,
	output logic                        byte_valid,
	output logic [7:0]                  byte_data
);

	import crc_core_pkg::*;

	crc_word_t  data_q;
	crc_word_t  lanes;
	crc_word_t  rev_data;
	logic [2:0] count_q;
	logic [2:0] count_load;
	logic [1:0] lane_sel;

	// Keep only the lanes the transfer carries
	always_comb
	begin
		case (wr_cmd.size)
			`HSIZE_BYTE:
			begin
				lanes      = {24'h0, wr_cmd.data[7:0]};
				count_load = 3'd1;
			end
			`HSIZE_HALF:
			begin
				lanes      = {16'h0, wr_cmd.data[15:0]};
				count_load = 3'd2;
			end
			default:
			begin
				lanes      = wr_cmd.data;
				count_load = 3'd4;
			end
		endcase
	end

	// Bit reversal never spans more than the transfer itself
	always_comb
	begin
		rev_data = lanes;
		if (cfg.rev_in != 2'b00)
			for (int b = 0; b < 4; b++)
			begin
				for (int k = 0; k < 8; k++)
					rev_data[8*b+k] = lanes[8*b+7-k];
			end
		if ((cfg.rev_in == 2'b10 && wr_cmd.size != `HSIZE_BYTE) ||
			(cfg.rev_in == 2'b11 && wr_cmd.size == `HSIZE_HALF))
			rev_data = {rev_data[23:16], rev_data[31:24], rev_data[7:0], rev_data[15:8]};
		else if (cfg.rev_in == 2'b11 && wr_cmd.size == `HSIZE_WORD)
			rev_data = {rev_data[7:0], rev_data[15:8], rev_data[23:16], rev_data[31:24]};
	end

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			count_q <= 3'd0;
		else if (buf_wr_en)
			count_q <= count_load;
		else if (byte_valid && byte_take)
			count_q <= count_q - 3'd1;
	end

	always_ff @(posedge HCLK)
	begin
		if (buf_wr_en)
			data_q <= rev_data;
	end

	// Most significant remaining byte goes first
	assign lane_sel    = count_q[1:0] - 2'd1;
	assign byte_data   = data_q[8*lane_sel +: 8];
	assign byte_valid  = (count_q != 3'd0);
	assign buffer_full = byte_valid;

endmodule

`default_nettype wire

/* hdl/crc_datapath.sv */
`timescale 1ns/10ps
`default_nettype none

`include "crc_defs.svh"

module crc_datapath
(
	input  wire                          HCLK,
	input  wire                          HRESETn,
	input  wire                          byte_valid,
	input  wire [7:0]                    byte_data,
	input  wire                          init_wr_en,
	input  wire                          pol_wr_en,
	input  wire                          idr_wr_en,
	input  wire crc_core_pkg::crc_word_t wr_data,
	input  wire                          reset_chain,
	input  wire crc_core_pkg::crc_cfg_t  cfg,
	output logic                         byte_take,
	output logic                         chain_busy,
	output crc_core_pkg::crc_word_t      crc_raw,
	output crc_core_pkg::crc_word_t      init_value,
	output crc_core_pkg::crc_word_t      pol_value,
	output logic [7:0]                   idr_value
);

	import crc_core_pkg::*;

	crc_word_t  crc_q;
	crc_word_t  crc_next;
	crc_word_t  init_q;
	crc_word_t  pol_q;
	logic [7:0] idr_q;
	crc_word_t  mask;
	logic [4:0] top;
	dp_state_e  state;

	assign top  = poly_top(cfg.poly_size);
	assign mask = poly_mask(cfg.poly_size);

	// A pending byte puts the engine in its shift state
	assign state = byte_valid ? DP_SHIFT : DP_IDLE;

	always_comb
	begin
		crc_word_t c;
		logic fb;
		c         = crc_q;
		fb        = 1'b0;
		byte_take = 1'b0;
		case (state)
			DP_SHIFT:
			begin
				byte_take = 1'b1;
				// Eight serial steps with data MSB first
				for (int i = 7; i >= 0; i--)
				begin
					fb = c[top] ^ byte_data[i];
					c  = (c << 1) & mask;
					if (fb)
						c = c ^ (pol_q & mask);
				end
			end
			default:
			begin
				// Chain reloads only happen while idle
				if (init_wr_en)
					c = wr_data;
				else if (reset_chain)
					c = init_q;
			end
		endcase
		crc_next = c;
	end

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			crc_q  <= `CRC_INIT_RESET;
			init_q <= `CRC_INIT_RESET;
			pol_q  <= `CRC_POL_RESET;
			idr_q  <= 8'h00;
		end
		else
		begin
			crc_q <= crc_next;
			if (init_wr_en)
				init_q <= wr_data;
			if (pol_wr_en)
				pol_q <= wr_data;
			if (idr_wr_en)
				idr_q <= wr_data[7:0];
		end
	end

	assign chain_busy = (state == DP_SHIFT);
	assign crc_raw    = crc_q;
	assign init_value = init_q;
	assign pol_value  = pol_q;
	assign idr_value  = idr_q;

endmodule

`default_nettype wire

/* hdl/crc_result_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module crc_result_stage
(
	input  wire crc_core_pkg::crc_word_t crc_raw,
	input  wire crc_core_pkg::crc_cfg_t  cfg,
	output crc_core_pkg::crc_word_t      crc_view
);

	import crc_core_pkg::*;

	crc_word_t  masked;
	crc_word_t  reversed;
	logic [4:0] top;

	assign top    = poly_top(cfg.poly_size);
	assign masked = crc_raw & poly_mask(cfg.poly_size);

	// Full word mirror shifted back down to the polynomial width
	always_comb
	begin
		for (int i = 0; i < 32; i++)
			reversed[i] = masked[31-i];
	end

	assign crc_view = cfg.rev_out ? (reversed >> (5'd31 - top)) : masked;

endmodule

`default_nettype wire

/* hdl/crc_unit_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "crc_defs.svh"

module crc_unit_top
(
	input  wire                       HCLK,
	input  wire                       HRESETn,
	input  wire                       hsel,
	input  wire [`CRC_BUS_W-1:0]      haddr,
	input  wire crc_ahb_pkg::htrans_t htrans,
	input  wire [2:0]                 hsize,
	input  wire                       hwrite,
	input  wire                       hready,
	input  wire [`CRC_BUS_W-1:0]      hwdata,
	output wire [`CRC_BUS_W-1:0]      hrdata,
	output wire                       hreadyout,
	output wire                       hresp
);

	import crc_core_pkg::*;

	// Decode to execute
	crc_wr_t   wr_cmd;
	crc_cfg_t  cfg;
	crc_word_t wr_data;
	wire       buf_wr_en;
	wire       init_wr_en;
	wire       pol_wr_en;
	wire       idr_wr_en;
	wire       reset_chain;

	// Execute and result back to decode
	wire        buffer_full;
	wire        chain_busy;
	crc_word_t  crc_raw;
	crc_word_t  crc_view;
	crc_word_t  init_value;
	crc_word_t  pol_value;
	wire [7:0]  idr_value;

	// Byte handshake inside execute
	wire       byte_valid;
	wire       byte_take;
	wire [7:0] byte_data;

	crc_ahb_regs i_crc_ahb_regs
	(
		.HCLK        (HCLK),
		.HRESETn     (HRESETn),
		.hsel        (hsel),
		.haddr       (haddr),
		.htrans      (htrans),
		.hsize       (hsize),
		.hwrite      (hwrite),
		.hready      (hready),
		.hwdata      (hwdata),
		.buffer_full (buffer_full),
		.chain_busy  (chain_busy),
		.crc_view    (crc_view),
		.init_value  (init_value),
		.pol_value   (pol_value),
		.idr_value   (idr_value),
		.hrdata      (hrdata),
		.hreadyout   (hreadyout),
		.hresp       (hresp),
		.buf_wr_en   (buf_wr_en),
		.wr_cmd      (wr_cmd),
		.init_wr_en  (init_wr_en),
		.pol_wr_en   (pol_wr_en),
		.idr_wr_en   (idr_wr_en),
		.wr_data     (wr_data),
		.reset_chain (reset_chain),
		.cfg         (cfg)
	);

	crc_data_buffer i_crc_data_buffer
	(
		.HCLK        (HCLK),
		.HRESETn     (HRESETn),
		.buf_wr_en   (buf_wr_en),
		.wr_cmd      (wr_cmd),
		.cfg         (cfg),
		.byte_take   (byte_take),
		.buffer_full (buffer_full),
		.byte_valid  (byte_valid),
		.byte_data   (byte_data)
	);

	crc_datapath i_crc_datapath
	(
		.HCLK        (HCLK),
		.HRESETn     (HRESETn),
		.byte_valid  (byte_valid),
		.byte_data   (byte_data),
		.init_wr_en  (init_wr_en),
		.pol_wr_en   (pol_wr_en),
		.idr_wr_en   (idr_wr_en),
		.wr_data     (wr_data),
		.reset_chain (reset_chain),
		.cfg         (cfg),
		.byte_take   (byte_take),
		.chain_busy  (chain_busy),
		.crc_raw     (crc_raw),
		.init_value  (init_value),
		.pol_value   (pol_value),
		.idr_value   (idr_value)
	);

	crc_result_stage i_crc_result_stage
	(
		.crc_raw  (crc_raw),
		.cfg      (cfg),
		.crc_view (crc_view)
	);

endmodule

`default_nettype wire

/* dv/crc_unit_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "crc_defs.svh"

module crc_unit_tb;

	localparam int N_WORDS = 8;
	localparam int N_SEQ   = 6;
	localparam int N_BURST = 2;
	localparam int N_IDR   = 8;
	// Transfers issued by all tests together
	localparam int XFERS = 5 + 2 * N_WORDS + 3 * (3 + 2 * N_SEQ) + 8 * 7 +
		6 * N_BURST + 6 * N_IDR;
	localparam int WATCHDOG_NS = (16 + 200 * XFERS) * 8;

	logic        HCLK;
	logic        HRESETn;
	logic        hsel;
	logic [31:0] haddr;
	logic [1:0]  htrans;
	logic [2:0]  hsize;
	logic        hwrite;
	logic        hready;
	logic [31:0] hwdata;
	wire  [31:0] hrdata;
	wire         hreadyout;
	wire         hresp;

	// Writes of the current chain for replay by the model
	logic [31:0] wl_data [0:15];
	logic [1:0]  wl_size [0:15];
	int          wl_n;

	logic [31:0] cur_init;
	logic [31:0] cur_pol;
	logic [4:0]  cur_cfg;
	logic        saw_wait;
	int          errors;
	int          n_checks;

	logic [31:0] chk_got;
	logic [31:0] chk_exp;
	string       chk_label;
	event        chk_ev;

	crc_unit_top i_crc_unit_top
	(
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.hsel      (hsel),
		.haddr     (haddr),
		.htrans    (htrans),
		.hsize     (hsize),
		.hwrite    (hwrite),
		.hready    (hready),
		.hwdata    (hwdata),
		.hrdata    (hrdata),
		.hreadyout (hreadyout),
		.hresp     (hresp)
	);

	initial
	begin
		HCLK = 1'b0;
		forever #4 HCLK = ~HCLK;
	end

	function automatic int bits_of(input logic [1:0] size);
		case (size)
			`HSIZE_BYTE: return 8;
			`HSIZE_HALF: return 16;
			default: return 32;
		endcase
	endfunction

	// Mirror bits within units no wider than the transfer
	function automatic logic [31:0] reverse_input(input logic [31:0] data,
		input logic [1:0] mode, input int nbits);
		logic [31:0] r;
		int          unit;
		r = '0;
		case (mode)
			2'b00: unit = 1;
			2'b01: unit = 8;
			2'b10: unit = 16;
			default: unit = 32;
		endcase
		if (unit > nbits)
			unit = nbits;
		for (int i = 0; i < nbits; i++)
			r[(i / unit) * unit + unit - 1 - i % unit] = data[i];
		return r;
	endfunction

	function automatic logic [31:0] crc_model(input logic [31:0] init,
		input logic [31:0] pol, input logic [4:0] cfg);
		logic [31:0] mask;
		logic [31:0] crc;
		logic [31:0] d;
		logic [31:0] view;
		logic        fb;
		int          top;
		int          nbits;
		case (cfg[1:0])
			2'b00: top = 31;
			2'b01: top = 15;
			2'b10: top = 7;
			default: top = 6;
		endcase
		mask = 32'hFFFF_FFFF >> (31 - top);
		crc  = init & mask;
		for (int w = 0; w < wl_n; w++)
		begin
			nbits = bits_of(wl_size[w]);
			d     = reverse_input(wl_data[w], cfg[3:2], nbits);
			// Serial update with data MSB first
			for (int b = nbits - 1; b >= 0; b--)
			begin
				fb  = crc[top] ^ d[b];
				crc = (crc << 1) & mask;
				if (fb)
					crc = crc ^ (pol & mask);
			end
		end
		view = crc;
		if (cfg[4])
		begin
			view = '0;
			for (int i = 0; i <= top; i++)
				view[i] = crc[top - i];
		end
		return view;
	endfunction

	// Single transfer of address phase and data phase with wait states
	task automatic ahb_xfer(input logic wr, input logic [2:0] idx, input logic [1:0] size,
		input logic [31:0] wdata, output logic [31:0] rdata);
		@(posedge HCLK);
		hsel   <= 1'b1;
		haddr  <= {27'h0, idx, 2'b00};
		htrans <= `HTRANS_NONSEQ;
		hwrite <= wr;
		hsize  <= {1'b0, size};
		@(negedge HCLK);
		while (!hreadyout)
			@(negedge HCLK);
		@(posedge HCLK);
		hsel   <= 1'b0;
		htrans <= 2'b00;
		if (wr)
			hwdata <= wdata;
		@(negedge HCLK);
		while (!hreadyout)
		begin
			saw_wait = 1'b1;
			@(negedge HCLK);
		end
		if (hresp !== 1'b0)
		begin
			errors++;
			$display("ERROR at %0t: HRESP is %b, expected OKAY", $time, hresp);
		end
		rdata = hrdata;
	endtask

	task automatic ahb_write(input logic [2:0] idx, input logic [1:0] size,
		input logic [31:0] data);
		logic [31:0] unused;
		ahb_xfer(1'b1, idx, size, data, unused);
	endtask

	task automatic read_check(input logic [2:0] idx, input logic [31:0] exp,
		input string label, output logic [31:0] got);
		ahb_xfer(1'b0, idx, `HSIZE_WORD, 32'h0, got);
		chk_got   = got;
		chk_exp   = exp;
		chk_label = label;
		->chk_ev;
	endtask

	task automatic dr_write(input logic [1:0] size, input logic [31:0] data);
		ahb_write(`CRC_DR_IDX, size, data);
		wl_data[wl_n] = data;
		wl_size[wl_n] = size;
		wl_n++;
	endtask

	task automatic dr_check(input string label);
		logic [31:0] got;
		read_check(`CRC_DR_IDX, crc_model(cur_init, cur_pol, cur_cfg), label, got);
	endtask

	// CR write with bit 0 set also restarts the chain from INIT
	task automatic set_config(input logic [4:0] cfg);
		ahb_write(`CRC_CR_IDX, `HSIZE_WORD, {24'h0, cfg, 3'b001});
		cur_cfg = cfg;
		wl_n    = 0;
	endtask

	always @(chk_ev)
	begin
		n_checks++;
		if (chk_got !== chk_exp)
		begin
			errors++;
			$display("ERROR at %0t: %s read %08h, expected %08h",
				$time, chk_label, chk_got, chk_exp);
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before all transfers completed");
		$display("test failed");
		$finish;
	end

	initial
	begin
		logic [31:0] got;
		logic [31:0] r;
		void'($urandom(32'hf0e314d2));
		HRESETn  = 1'b0;
		hsel     = 1'b0;
		haddr    = '0;
		htrans   = 2'b00;
		hsize    = 3'b000;
		hwrite   = 1'b0;
		hready   = 1'b1;
		hwdata   = '0;
		wl_n     = 0;
		errors   = 0;
		n_checks = 0;
		saw_wait = 1'b0;
		cur_init = `CRC_INIT_RESET;
		cur_pol  = `CRC_POL_RESET;
		cur_cfg  = 5'b00000;
		repeat (16) @(posedge HCLK);
		HRESETn <= 1'b1;

		read_check(`CRC_INIT_IDX, 32'hFFFF_FFFF, "INIT after reset", got);
		read_check(`CRC_POL_IDX, 32'h04C1_1DB7, "POL after reset", got);
		read_check(`CRC_CR_IDX, 32'h0, "CR after reset", got);
		read_check(`CRC_IDR_IDX, 32'h0, "IDR after reset", got);
		read_check(`CRC_DR_IDX, 32'hFFFF_FFFF, "DR after reset", got);

		// CRC-32 over random words
		for (int i = 0; i < N_WORDS; i++)
		begin
			dr_write(`HSIZE_WORD, $urandom);
			dr_check("DR after word write");
		end

		// Short polynomials with byte and halfword data
		for (int p = 1; p < 4; p++)
		begin
			cur_pol  = $urandom;
			cur_init = $urandom;
			ahb_write(`CRC_POL_IDX, `HSIZE_WORD, cur_pol);
			ahb_write(`CRC_INIT_IDX, `HSIZE_WORD, cur_init);
			set_config({3'b000, p[1:0]});
			for (int i = 0; i < N_SEQ; i++)
			begin
				r = $urandom;
				dr_write(r[0] ? `HSIZE_HALF : `HSIZE_BYTE, $urandom);
				dr_check("DR after short write");
			end
		end

		// Input reversal modes with output reversal off and on
		for (int i = 0; i < 8; i++)
		begin
			r = $urandom;
			set_config({i[2], i[1:0], r[1:0]});
			dr_write(`HSIZE_WORD, $urandom);
			dr_check("DR with reversal, word");
			dr_write(`HSIZE_HALF, $urandom);
			dr_check("DR with reversal, halfword");
			dr_write(`HSIZE_WORD, $urandom);
			dr_check("DR with reversal, second word");
		end

		// Back-to-back writes with the read right behind them
		for (int n = 0; n < N_BURST; n++)
		begin
			set_config(5'b00000);
			saw_wait = 1'b0;
			for (int i = 0; i < 4; i++)
				dr_write(`HSIZE_WORD, $urandom);
			if (!saw_wait)
			begin
				errors++;
				$display("No wait state was seen during the back-to-back DR writes");
			end
			dr_check("DR after write burst");
		end

		// Scratch register and CR readback
		for (int i = 0; i < N_IDR; i++)
		begin
			read_check(`CRC_DR_IDX, crc_model(cur_init, cur_pol, cur_cfg),
				"DR before IDR write", got);
			r = $urandom;
			ahb_write(`CRC_IDR_IDX, `HSIZE_WORD, r);
			read_check(`CRC_IDR_IDX, {24'h0, r[7:0]}, "IDR readback", got);
			read_check(`CRC_DR_IDX, crc_model(cur_init, cur_pol, cur_cfg),
				"DR after IDR write", got);
			r = $urandom;
			set_config(r[7:3]);
			read_check(`CRC_CR_IDX, {24'h0, r[7:3], 3'b000}, "CR readback", got);
		end

		repeat (2) @(posedge HCLK);
		$display("Checks: %0d, errors: %0d", n_checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+hdl
hdl/crc_ahb_pkg.sv
hdl/crc_core_pkg.sv
hdl/crc_ahb_regs.sv
hdl/crc_data_buffer.sv
hdl/crc_datapath.sv
hdl/crc_result_stage.sv
hdl/crc_unit_top.sv
dv/crc_unit_tb.sv
